//--- hw/pong_pkg.sv
// court geometry, frame timing and the types shared by the ball engine
// geometry assumes 4 pixel wide paddles set 2 pixels in from each side edge
package pong_pkg;

	// court size in pixels
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;

	// ball and paddle shape
	localparam int BOX = 4;
	localparam int PADDLE_H = 15;
	localparam int PADDLE_W = 4;
	localparam int PADDLE_OFFSET = 2;
	localparam int Y_MARGIN = 20;

	// limits of the ball origin, top left corner of the box
	localparam int Y_MIN = Y_MARGIN;
	localparam int Y_MAX = SCREEN_H - 1 - BOX - Y_MARGIN;
	localparam int X_MIN = PADDLE_W + PADDLE_OFFSET;
	localparam int X_MAX = SCREEN_W - 1 - BOX - PADDLE_W - PADDLE_OFFSET;

	// serve position
	localparam int CENTER_X = SCREEN_W / 2;
	localparam int CENTER_Y = SCREEN_H / 2;

	// pixels moved per frame
	localparam int RATE_MIN = 1;
	localparam int RATE_MAX = 5;

	// moves between rate increments
	localparam int MOVES_PER_ACCEL = 30;
	localparam int ACCEL_W = $clog2(MOVES_PER_ACCEL);

	// box scan counter width
	localparam int BOX_CNT_W = $clog2(BOX);

	// 50 MHz clock, 60 Hz frames
	localparam int CLOCKS_PER_FRAME = 833333;

	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;
	typedef logic [2:0] rate_t;
	typedef logic [2:0] colour_t;

	// ball position, the position before the last move, and speed
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		coord_x_t old_x;
		coord_y_t old_y;
		rate_t    rate;
	} ball_state_t;

	// direction for the next move; serve sends the ball to the centre
	typedef struct packed {
		logic x_right;
		logic y_down;
		logic serve;
	} move_t;

	// one cycle game events, at most one set per move
	typedef struct packed {
		logic lhs_score;
		logic rhs_score;
		logic bounce;
	} court_event_t;

	// one framebuffer write
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
		logic     plot;
	} pixel_t;

	typedef enum logic [1:0] {
		DRAW_IDLE,
		DRAW_CLEAR,
		DRAW_NEW
	} draw_state_t;

endpackage

//--- hw/frame_timer.sv
// frame tick generator; clocks_per_frame must be at least 40 so a box redraw
// finishes inside one frame
module frame_timer
	import pong_pkg::*;
#(
	parameter int clocks_per_frame = CLOCKS_PER_FRAME
) (
	input  logic clk,
	input  logic resetn,
	input  logic enable,
	output logic frame_tick
);
	typedef logic [$clog2(clocks_per_frame)-1:0] count_t;

	// counts down the enabled clocks left in this frame
	count_t count;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= count_t'(clocks_per_frame - 1);
			frame_tick <= 1'b0;
		end else if (enable) begin
			if (count == '0) begin
				// last enabled clock of the frame, reload and tick
				count <= count_t'(clocks_per_frame - 1);
				frame_tick <= 1'b1;
			end else begin
				count <= count - 1'b1;
				frame_tick <= 1'b0;
			end
		end else begin
			// paused, counter holds
			frame_tick <= 1'b0;
		end
	end

endmodule

//--- hw/box_scanner.sv
// walks a BOX x BOX square in row-major order, one pixel per clock
// origin is latched on start; a start on the last pixel chains a new scan
module box_scanner
	import pong_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     start,
	input  coord_x_t org_x,
	input  coord_y_t org_y,
	output coord_x_t pt_x,
	output coord_y_t pt_y,
	output logic     active,
	output logic     done
);
	logic [BOX_CNT_W-1:0] col;
	logic [BOX_CNT_W-1:0] row;
	coord_x_t base_x;
	coord_y_t base_y;
	logic last;

	// bottom right pixel of the box
	assign last = (col == BOX_CNT_W'(BOX - 1)) && (row == BOX_CNT_W'(BOX - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (start) begin
			active <= 1'b1;
			col <= '0;
			row <= '0;
		end else if (active) begin
			if (last) begin
				active <= 1'b0;
				col <= '0;
				row <= '0;
			end else if (col == BOX_CNT_W'(BOX - 1)) begin
				// next row, back to the left column
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			base_x <= org_x;
			base_y <= org_y;
		end
	end

	assign pt_x = base_x + coord_x_t'(col);
	assign pt_y = base_y + coord_y_t'(row);
	assign done = active && last;

endmodule

//--- hw/court_rules.sv
// wall, paddle and score decisions, taken once per frame tick
// results appear one cycle after the tick and last exactly one cycle
module court_rules
	import pong_pkg::*;
(
	input  logic         clk,
	input  logic         resetn,
	input  logic         frame_tick,
	input  ball_state_t  ball,
	input  coord_y_t     lhs_paddle_y,
	input  coord_y_t     rhs_paddle_y,
	output move_t        move,
	output logic         move_valid,
	output court_event_t events
);
	// current directions, 1 is right or down
	logic x_right;
	logic y_down;
	logic serve_q;

	// decisions for the coming move
	logic next_x_right;
	logic next_y_down;
	logic next_serve;
	court_event_t next_events;

	// reach limits at the current rate
	coord_x_t x_lo;
	coord_x_t x_hi;
	coord_y_t y_lo;
	coord_y_t y_hi;

	// true overlap of ball rows and paddle rows, 9 bits so the sums cannot wrap
	function automatic logic paddle_overlap(coord_y_t ball_y, coord_y_t pad_y);
		logic [8:0] ball_bot;
		logic [8:0] pad_bot;
		ball_bot = {1'b0, ball_y} + 9'(BOX);
		pad_bot = {1'b0, pad_y} + 9'(PADDLE_H);
		return ({1'b0, ball_y} < pad_bot) && (ball_bot > {1'b0, pad_y});
	endfunction

	assign x_lo = coord_x_t'(X_MIN) + coord_x_t'(ball.rate);
	assign x_hi = coord_x_t'(X_MAX) - coord_x_t'(ball.rate);
	assign y_lo = coord_y_t'(Y_MIN) + coord_y_t'(ball.rate);
	assign y_hi = coord_y_t'(Y_MAX) - coord_y_t'(ball.rate);

	always_comb begin
		next_x_right = x_right;
		next_y_down = y_down;
		next_serve = 1'b0;
		next_events = '0;

		// top and bottom walls
		if (y_down && ball.y > y_hi) begin
			next_y_down = 1'b0;
			next_events.bounce = 1'b1;
		end else if (!y_down && ball.y < y_lo) begin
			next_y_down = 1'b1;
			next_events.bounce = 1'b1;
		end

		// left edge, paddle or a point for the right player
		if (!x_right && ball.x < x_lo) begin
			if (paddle_overlap(ball.y, lhs_paddle_y)) begin
				next_x_right = 1'b1;
				next_events.bounce = 1'b1;
			end else begin
				// serve keeps heading left, vertical direction as before
				next_serve = 1'b1;
				next_y_down = y_down;
				next_events = '{lhs_score: 1'b0, rhs_score: 1'b1, bounce: 1'b0};
			end
		end else if (x_right && ball.x > x_hi) begin
			if (paddle_overlap(ball.y, rhs_paddle_y)) begin
				next_x_right = 1'b0;
				next_events.bounce = 1'b1;
			end else begin
				// serve keeps heading right
				next_serve = 1'b1;
				next_y_down = y_down;
				next_events = '{lhs_score: 1'b1, rhs_score: 1'b0, bounce: 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			// start moving right and down
			x_right <= 1'b1;
			y_down <= 1'b1;
			serve_q <= 1'b0;
			move_valid <= 1'b0;
			events <= '0;
		end else begin
			move_valid <= frame_tick;
			if (frame_tick) begin
				x_right <= next_x_right;
				y_down <= next_y_down;
				serve_q <= next_serve;
				events <= next_events;
			end else begin
				events <= '0;
			end
		end
	end

	assign move = '{x_right: x_right, y_down: y_down, serve: serve_q};

endmodule

//--- hw/ball_physics.sv
// ball position and speed; a move takes effect the cycle after its strobe
// court_rules keeps the ball inside its limits, nothing is clamped here
module ball_physics
	import pong_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  move_t       move,
	input  logic        move_valid,
	output ball_state_t ball
);
	ball_state_t state;

	// moves since the last rate change or serve
	logic [ACCEL_W-1:0] move_count;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			// at rest in the centre, old box on top of the new one
			state.x <= coord_x_t'(CENTER_X);
			state.y <= coord_y_t'(CENTER_Y);
			state.old_x <= coord_x_t'(CENTER_X);
			state.old_y <= coord_y_t'(CENTER_Y);
			state.rate <= rate_t'(RATE_MIN);
			move_count <= '0;
		end else if (move_valid) begin
			// drawer needs the box it has to erase
			state.old_x <= state.x;
			state.old_y <= state.y;
			if (move.serve) begin
				state.x <= coord_x_t'(CENTER_X);
				state.y <= coord_y_t'(CENTER_Y);
				state.rate <= rate_t'(RATE_MIN);
				move_count <= '0;
			end else begin
				state.x <= move.x_right ? state.x + coord_x_t'(state.rate)
				                        : state.x - coord_x_t'(state.rate);
				state.y <= move.y_down ? state.y + coord_y_t'(state.rate)
				                       : state.y - coord_y_t'(state.rate);
				if (move_count == ACCEL_W'(MOVES_PER_ACCEL - 1)) begin
					// speed up, saturating
					move_count <= '0;
					if (state.rate != rate_t'(RATE_MAX)) begin
						state.rate <= state.rate + 1'b1;
					end
				end else begin
					move_count <= move_count + 1'b1;
				end
			end
		end
	end

	assign ball = state;

endmodule

//--- hw/draw_sequencer.sv
// erases the old box in colour 0, then draws the new box, after every move
// 32 back-to-back plot cycles; no back-pressure, moves outside idle are ignored
module draw_sequencer
	import pong_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        move_valid,
	input  ball_state_t ball,
	input  colour_t     colour,
	output pixel_t      pixel
);
	draw_state_t state;

	// kick for the erase scan, lands when the moved ball is visible
	logic start_q;
	logic start;
	coord_x_t org_x;
	coord_y_t org_y;

	// scanner outputs
	coord_x_t pt_x;
	coord_y_t pt_y;
	logic active;
	logic done;

	// registered pixel fields
	coord_x_t pix_x;
	coord_y_t pix_y;
	colour_t pix_colour;
	logic plot_q;

	// erase scan first, draw scan starts on the last erase pixel
	assign start = start_q || (state == DRAW_CLEAR && done);
	assign org_x = start_q ? ball.old_x : ball.x;
	assign org_y = start_q ? ball.old_y : ball.y;

	box_scanner u_scan (
		.clk    (clk),
		.resetn (resetn),
		.start  (start),
		.org_x  (org_x),
		.org_y  (org_y),
		.pt_x   (pt_x),
		.pt_y   (pt_y),
		.active (active),
		.done   (done)
	);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= DRAW_IDLE;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
				DRAW_IDLE: begin
					if (move_valid) begin
						state <= DRAW_CLEAR;
						start_q <= 1'b1;
					end
				end
				DRAW_CLEAR: begin
					if (done) begin
						state <= DRAW_NEW;
					end
				end
				DRAW_NEW: begin
					if (done) begin
						state <= DRAW_IDLE;
					end
				end
				default: begin
					state <= DRAW_IDLE;
				end
			endcase
		end
	end

	// pixel payload, meaningful only while plot is high
	always_ff @(posedge clk) begin
		pix_x <= pt_x;
		pix_y <= pt_y;
		pix_colour <= (state == DRAW_NEW) ? colour : '0;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			plot_q <= 1'b0;
		end else begin
			plot_q <= active;
		end
	end

	assign pixel = '{x: pix_x, y: pix_y, colour: pix_colour, plot: plot_q};

endmodule

//--- hw/pong_ball.sv
// ball engine of a two-player paddle game on a 320x240 court
// clocks_per_frame must be at least 40; paddle rows are the top row of each paddle
module pong_ball
	import pong_pkg::*;
#(
	parameter int clocks_per_frame = CLOCKS_PER_FRAME
) (
	input  logic         clk,
	input  logic         resetn,
	input  logic         enable,
	input  colour_t      colour,
	input  coord_y_t     lhs_paddle_y,
	input  coord_y_t     rhs_paddle_y,
	output ball_state_t  ball,
	output court_event_t events,
	output pixel_t       pixel
);
	logic frame_tick;
	move_t move;
	logic move_valid;

	// frame pacing, stops while paused
	frame_timer #(
		.clocks_per_frame (clocks_per_frame)
	) u_timer (
		.clk        (clk),
		.resetn     (resetn),
		.enable     (enable),
		.frame_tick (frame_tick)
	);

	court_rules u_rules (
		.clk          (clk),
		.resetn       (resetn),
		.frame_tick   (frame_tick),
		.ball         (ball),
		.lhs_paddle_y (lhs_paddle_y),
		.rhs_paddle_y (rhs_paddle_y),
		.move         (move),
		.move_valid   (move_valid),
		.events       (events)
	);

	ball_physics u_physics (
		.clk        (clk),
		.resetn     (resetn),
		.move       (move),
		.move_valid (move_valid),
		.ball       (ball)
	);

	// redraw follows the move strobe
	draw_sequencer u_draw (
		.clk        (clk),
		.resetn     (resetn),
		.move_valid (move_valid),
		.ball       (ball),
		.colour     (colour),
		.pixel      (pixel)
	);

endmodule

//--- tests/pong_ball_sva.sv
// concurrent checks on the ball engine outputs, bound into pong_ball
// a redraw is 32 back-to-back plot cycles and events are one cycle strobes
module pong_ball_sva
	import pong_pkg::*;
(
	input logic         clk,
	input logic         resetn,
	input ball_state_t  ball,
	input court_event_t events,
	input pixel_t       pixel
);
	timeunit 1ns;
	timeprecision 1ps;

	// cycles in the current plot run
	logic [5:0] run_len;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			run_len <= '0;
		end else if (pixel.plot) begin
			run_len <= run_len + 1'b1;
		end else begin
			run_len <= '0;
		end
	end

	events_exclusive: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0(events))
		else $error("more than one court event at once");

	events_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		(events != '0) |=> (events == '0))
		else $error("court event held for more than one cycle");

	// run must end at exactly 32
	plot_run_short: assert property (@(posedge clk) disable iff (!resetn)
		$fell(pixel.plot) |-> (run_len == 6'd32))
		else $error("plot run ended early");

	plot_run_long: assert property (@(posedge clk) disable iff (!resetn)
		pixel.plot |-> (run_len < 6'd32))
		else $error("plot run longer than 32 cycles");

	ball_in_court: assert property (@(posedge clk) disable iff (!resetn)
		int'(ball.x) >= X_MIN && int'(ball.x) <= X_MAX
		&& int'(ball.y) >= Y_MIN && int'(ball.y) <= Y_MAX)
		else $error("ball origin outside the court limits");

endmodule

//--- tests/pong_ball_tb.sv
// drives the ball engine through a scenario table and checks every move and redraw
// against a reference model; frames are 64 clocks so each redraw ends well inside one
module pong_ball_tb
	import pong_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// how the paddle rows of a table step are chosen
	typedef enum logic [1:0] {
		PAD_FIXED,
		PAD_RANDOM,
		PAD_TRACK
	} paddle_mode_t;

	typedef struct packed {
		paddle_mode_t mode;
		coord_y_t     lhs;
		coord_y_t     rhs;
		logic         enable;
		logic [8:0]   moves;
		colour_t      colour;
	} step_t;

	logic clk;
	logic resetn;
	logic enable;
	colour_t colour;
	coord_y_t lhs_paddle_y;
	coord_y_t rhs_paddle_y;
	ball_state_t ball;
	court_event_t events;
	pixel_t pixel;

	// reference model of the ball
	int mx;
	int my;
	int mr;
	int mcnt;
	logic mxr;
	logic myd;

	int frame_clocks;
	int errors;
	int checks;
	int bounces;
	int scores;
	int max_rate;
	logic timed_out;
	logic [31:0] seed;
	step_t steps [7];

	pong_ball #(
		.clocks_per_frame (64)
	) dut (
		.clk          (clk),
		.resetn       (resetn),
		.enable       (enable),
		.colour       (colour),
		.lhs_paddle_y (lhs_paddle_y),
		.rhs_paddle_y (rhs_paddle_y),
		.ball         (ball),
		.events       (events),
		.pixel        (pixel)
	);

	bind pong_ball pong_ball_sva u_sva (
		.clk    (clk),
		.resetn (resetn),
		.ball   (ball),
		.events (events),
		.pixel  (pixel)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ball rows against paddle rows
	function automatic logic overlaps(input int ball_y, input int pad_y);
		return (ball_y < pad_y + PADDLE_H) && (ball_y + BOX > pad_y);
	endfunction

	// advances the model by one move and returns the event the court should raise
	task automatic predict_move(input int lp, input int rp, output court_event_t ev);
		logic nxr;
		logic nyd;
		ev = '0;
		nxr = mxr;
		nyd = myd;
		// walls
		if (myd && my > Y_MAX - mr) begin
			nyd = 1'b0;
			ev.bounce = 1'b1;
		end else if (!myd && my < Y_MIN + mr) begin
			nyd = 1'b1;
			ev.bounce = 1'b1;
		end
		// at an edge a miss scores and keeps the vertical direction
		if (!mxr && mx < X_MIN + mr) begin
			if (overlaps(my, lp)) begin
				nxr = 1'b1;
				ev.bounce = 1'b1;
			end else begin
				ev = '0;
				ev.rhs_score = 1'b1;
				nyd = myd;
			end
		end else if (mxr && mx > X_MAX - mr) begin
			if (overlaps(my, rp)) begin
				nxr = 1'b0;
				ev.bounce = 1'b1;
			end else begin
				ev = '0;
				ev.lhs_score = 1'b1;
				nyd = myd;
			end
		end
		mxr = nxr;
		myd = nyd;
		if (ev.lhs_score || ev.rhs_score) begin
			// serve from the centre at the lowest rate
			mx = CENTER_X;
			my = CENTER_Y;
			mr = RATE_MIN;
			mcnt = 0;
		end else begin
			mx = mxr ? mx + mr : mx - mr;
			my = myd ? my + mr : my - mr;
			mcnt++;
			if (mcnt == MOVES_PER_ACCEL) begin
				mcnt = 0;
				if (mr < RATE_MAX) begin
					mr++;
				end
			end
		end
	endtask

	// collects the events seen on the way
	task automatic wait_for_move(input ball_state_t prev, output court_event_t seen);
		int n;
		seen = '0;
		n = 0;
		while (ball == prev && !timed_out) begin
			@(negedge clk);
			seen = seen | events;
			n++;
			if (n > 4 * frame_clocks) begin
				timed_out = 1'b1;
				$display("timeout: the ball did not move within %0d clocks, at %0t", n, $time);
			end
		end
	endtask

	task automatic check_ball(input int ox, input int oy, input court_event_t exp_ev,
	                          input court_event_t seen);
		checks++;
		assert (int'(ball.x) == mx && int'(ball.y) == my && int'(ball.old_x) == ox
		        && int'(ball.old_y) == oy && int'(ball.rate) == mr) else begin
			errors++;
			$write("Mismatch at %0t: ball (%0d,%0d) old (%0d,%0d) rate %0d,",
			       $time, ball.x, ball.y, ball.old_x, ball.old_y, ball.rate);
			$display(" expected (%0d,%0d) old (%0d,%0d) rate %0d", mx, my, ox, oy, mr);
		end
		checks++;
		assert (seen == exp_ev) else begin
			errors++;
			$display("Mismatch at %0t: events %b, expected %b", $time, seen, exp_ev);
		end
	endtask

	// 16 erase pixels then 16 draw pixels in row-major order
	task automatic check_pixels(input int ox, input int oy, input int nx, input int ny,
	                            input colour_t c);
		int n;
		int i;
		int ex;
		int ey;
		colour_t ec;
		n = 0;
		while (!pixel.plot && !timed_out) begin
			@(negedge clk);
			n++;
			if (n > 16) begin
				timed_out = 1'b1;
				$display("timeout: no pixel plotted after the move, at %0t", $time);
			end
		end
		for (i = 0; i < 2 * BOX * BOX && !timed_out; i++) begin
			ex = ((i < BOX * BOX) ? ox : nx) + i % BOX;
			ey = ((i < BOX * BOX) ? oy : ny) + (i % (BOX * BOX)) / BOX;
			ec = (i < BOX * BOX) ? colour_t'(0) : c;
			checks++;
			assert (pixel.plot && int'(pixel.x) == ex && int'(pixel.y) == ey
			        && pixel.colour == ec) else begin
				errors++;
				$write("Mismatch at %0t: pixel %0d at (%0d,%0d) colour %0d plot %0b,",
				       $time, i, pixel.x, pixel.y, pixel.colour, pixel.plot);
				$display(" expected (%0d,%0d) colour %0d", ex, ey, ec);
			end
			@(negedge clk);
		end
		checks++;
		assert (!pixel.plot) else begin
			errors++;
			$display("Mismatch at %0t: plot still high after 32 pixels", $time);
		end
	endtask

	// while paused nothing may move or plot
	task automatic hold_paused(input int frames);
		ball_state_t held;
		int n;
		held = ball;
		for (n = 0; n < frames * frame_clocks; n++) begin
			@(negedge clk);
			checks++;
			assert (ball == held && !pixel.plot && events == '0) else begin
				errors++;
				$display("Mismatch at %0t: activity while paused, plot %0b events %b",
				         $time, pixel.plot, events);
			end
		end
	endtask

	initial begin
		ball_state_t prev;
		court_event_t exp_ev;
		court_event_t seen;
		int s;
		int m;
		int ox;
		int oy;
		int lp;
		int rp;
		resetn = 1'b0;
		enable = 1'b0;
		colour = '0;
		lhs_paddle_y = '0;
		rhs_paddle_y = '0;
		// frame period of the DUT, sizes the timeouts and the pause
		frame_clocks = dut.clocks_per_frame;
		errors = 0;
		checks = 0;
		bounces = 0;
		scores = 0;
		max_rate = 0;
		timed_out = 1'b0;
		seed = 32'hcb43;
		mx = CENTER_X;
		my = CENTER_Y;
		mr = RATE_MIN;
		mcnt = 0;
		mxr = 1'b1;
		myd = 1'b1;

		// tracking paddles never miss and paddles at row 0 always miss
		steps[0] = '{PAD_TRACK, 8'd0, 8'd0, 1'b1, 9'd200, 3'd3};
		steps[1] = '{PAD_FIXED, 8'd0, 8'd0, 1'b0, 9'd0, 3'd3};
		steps[2] = '{PAD_FIXED, 8'd0, 8'd0, 1'b1, 9'd80, 3'd5};
		steps[3] = '{PAD_RANDOM, 8'd0, 8'd0, 1'b1, 9'd160, 3'd6};
		steps[4] = '{PAD_TRACK, 8'd0, 8'd0, 1'b1, 9'd40, 3'd2};
		steps[5] = '{PAD_FIXED, 8'd0, 8'd0, 1'b0, 9'd0, 3'd2};
		steps[6] = '{PAD_RANDOM, 8'd0, 8'd0, 1'b1, 9'd40, 3'd7};

		checks++;
		assert (frame_clocks >= 40) else begin
			errors++;
			$display("frame period of %0d clocks is too short for a redraw", frame_clocks);
		end

		repeat (3) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		checks++;
		assert (int'(ball.x) == CENTER_X && int'(ball.y) == CENTER_Y
		        && int'(ball.old_x) == CENTER_X && int'(ball.old_y) == CENTER_Y
		        && int'(ball.rate) == RATE_MIN && events == '0 && !pixel.plot) else begin
			errors++;
			$display("Mismatch at %0t: reset state ball (%0d,%0d) old (%0d,%0d) rate %0d",
			         $time, ball.x, ball.y, ball.old_x, ball.old_y, ball.rate);
		end

		for (s = 0; s < 7 && !timed_out; s++) begin
			colour = steps[s].colour;
			enable = steps[s].enable;
			if (!steps[s].enable) begin
				hold_paused(5);
			end
			for (m = 0; m < int'(steps[s].moves) && !timed_out; m++) begin
				case (steps[s].mode)
					PAD_TRACK: begin
						lp = my - 5;
						rp = my - 5;
					end
					PAD_RANDOM: begin
						// rows near the ball overlap it more often than not
						seed = lcg_next(seed);
						lp = my - 20 + int'(seed[23:16]) % 30;
						seed = lcg_next(seed);
						rp = my - 20 + int'(seed[23:16]) % 30;
					end
					default: begin
						lp = int'(steps[s].lhs);
						rp = int'(steps[s].rhs);
					end
				endcase
				lhs_paddle_y = coord_y_t'(lp);
				rhs_paddle_y = coord_y_t'(rp);
				prev = ball;
				ox = mx;
				oy = my;
				predict_move(lp, rp, exp_ev);
				wait_for_move(prev, seen);
				if (!timed_out) begin
					check_ball(ox, oy, exp_ev, seen);
					check_pixels(ox, oy, mx, my, colour);
					bounces += int'(seen.bounce);
					scores += int'(seen.lhs_score) + int'(seen.rhs_score);
					if (int'(ball.rate) > max_rate) begin
						max_rate = int'(ball.rate);
					end
				end
			end
		end

		if (!timed_out) begin
			checks++;
			assert (bounces > 0 && scores > 0 && max_rate == RATE_MAX) else begin
				errors++;
				$display("scenarios missed a case: bounces %0d, scores %0d, top rate %0d",
				         bounces, scores, max_rate);
			end
		end

		$display("checks %0d, errors %0d, bounces %0d, scores %0d, timeout %0b",
		         checks, errors, bounces, scores, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
hw/pong_pkg.sv
hw/frame_timer.sv
hw/box_scanner.sv
hw/court_rules.sv
hw/ball_physics.sv
hw/draw_sequencer.sv
hw/pong_ball.sv
tests/pong_ball_sva.sv
tests/pong_ball_tb.sv

//--- Makefile
TOP := pong_ball_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f vlog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
